// File: soc_config.svh
// Fixed 32-bit bus; windows must not overlap and each must fit the 12-bit APB offset
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Bus widths
`define SOC_ADDR_WIDTH 32
`define SOC_DATA_WIDTH 32
`define SOC_SEL_WIDTH 4
`define SOC_APB_ADDR_WIDTH 12

// On-chip memory depth in words covering the whole memory window
`define SOC_L2_WORDS 1024

// Memory map
`define SOC_DRAM_BASE 32'h8000_0000
`define SOC_DRAM_LENGTH 32'h0000_1000
`define SOC_UART_BASE 32'hC000_0000
`define SOC_UART_LENGTH 32'h0000_1000
`define SOC_CTRL_BASE 32'hD000_0000
`define SOC_CTRL_LENGTH 32'h0000_1000

`endif

// File: soc_pkg.sv
// Shared enums and byte-merge helper; register offsets assume 32-bit words
`include "soc_config.svh"

package soc_pkg;

  // Decoder target select
  typedef enum logic [1:0] {
    TGT_L2,
    TGT_UART,
    TGT_CTRL,
    TGT_NONE
  } soc_target_e;

  // Control block word offsets
  typedef enum logic [`SOC_APB_ADDR_WIDTH-1:0] {
    REG_EXIT      = 12'h000,
    REG_HW_CNT_EN = 12'h004,
    REG_DRAM_BASE = 12'h008,
    REG_DRAM_END  = 12'h00C
  } ctrl_reg_e;

  // Bus-to-APB bridge states
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS,
    APB_DONE
  } apb_state_e;

  // Replace only the bytes whose select bit is set
  function automatic logic [`SOC_DATA_WIDTH-1:0] apply_sel(
    input logic [`SOC_DATA_WIDTH-1:0] old_word,
    input logic [`SOC_DATA_WIDTH-1:0] new_word,
    input logic [`SOC_SEL_WIDTH-1:0]  sel
  );
    logic [`SOC_DATA_WIDTH-1:0] merged;
    merged = old_word;
    for (int i = 0; i < `SOC_SEL_WIDTH; i++) begin
      if (sel[i]) merged[8*i +: 8] = new_word[8*i +: 8];
    end
    return merged;
  endfunction

endpackage

// File: wb_if.sv
// Wishbone classic, one transfer in flight; master holds requests until ack or err
`timescale 1ns/1ps
`include "soc_config.svh"

interface wb_if;

  logic                       cyc;
  logic                       stb;
  logic                       we;
  logic [`SOC_ADDR_WIDTH-1:0] adr;
  logic [`SOC_DATA_WIDTH-1:0] dat_w;
  logic [`SOC_SEL_WIDTH-1:0]  sel;
  logic [`SOC_DATA_WIDTH-1:0] dat_r;
  logic                       ack;
  logic                       err;

  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack, err
  );

endinterface

// File: soc_decoder.sv
// Single-master decoder; targets see window offsets, unmapped addresses end with err
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_decoder import soc_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`SOC_ADDR_WIDTH-1:0] wb_adr_i,
  input  logic [`SOC_DATA_WIDTH-1:0] wb_dat_i,
  input  logic [`SOC_SEL_WIDTH-1:0]  wb_sel_i,
  output logic [`SOC_DATA_WIDTH-1:0] wb_dat_o,
  output logic                       wb_ack_o,
  output logic                       wb_err_o,
  wb_if.master                       l2_bus,
  wb_if.master                       uart_bus,
  wb_if.master                       ctrl_bus
);

  soc_target_e                tgt;
  logic [`SOC_ADDR_WIDTH-1:0] win_offset;
  logic                       none_err_q;

  ////////////////////////////////////////
  // Address classification
  ////////////////////////////////////////

  always_comb begin
    tgt        = TGT_NONE;
    win_offset = '0;
    if (wb_adr_i >= `SOC_DRAM_BASE && wb_adr_i - `SOC_DRAM_BASE < `SOC_DRAM_LENGTH) begin
      tgt        = TGT_L2;
      win_offset = wb_adr_i - `SOC_DRAM_BASE;
    end else if (wb_adr_i >= `SOC_UART_BASE &&
                 wb_adr_i - `SOC_UART_BASE < `SOC_UART_LENGTH) begin
      tgt        = TGT_UART;
      win_offset = wb_adr_i - `SOC_UART_BASE;
    end else if (wb_adr_i >= `SOC_CTRL_BASE &&
                 wb_adr_i - `SOC_CTRL_BASE < `SOC_CTRL_LENGTH) begin
      tgt        = TGT_CTRL;
      win_offset = wb_adr_i - `SOC_CTRL_BASE;
    end
  end

  // Only the selected target sees cyc and stb
  assign l2_bus.cyc   = wb_cyc_i & (tgt == TGT_L2);
  assign l2_bus.stb   = wb_stb_i & (tgt == TGT_L2);
  assign uart_bus.cyc = wb_cyc_i & (tgt == TGT_UART);
  assign uart_bus.stb = wb_stb_i & (tgt == TGT_UART);
  assign ctrl_bus.cyc = wb_cyc_i & (tgt == TGT_CTRL);
  assign ctrl_bus.stb = wb_stb_i & (tgt == TGT_CTRL);

  assign l2_bus.we     = wb_we_i;
  assign l2_bus.adr    = win_offset;
  assign l2_bus.dat_w  = wb_dat_i;
  assign l2_bus.sel    = wb_sel_i;
  assign uart_bus.we    = wb_we_i;
  assign uart_bus.adr   = win_offset;
  assign uart_bus.dat_w = wb_dat_i;
  assign uart_bus.sel   = wb_sel_i;
  assign ctrl_bus.we    = wb_we_i;
  assign ctrl_bus.adr   = win_offset;
  assign ctrl_bus.dat_w = wb_dat_i;
  assign ctrl_bus.sel   = wb_sel_i;

  // Unmapped cycle ends with err one cycle after stb and never twice in a row
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      none_err_q <= 1'b0;
    end else begin
      none_err_q <= wb_cyc_i & wb_stb_i & (tgt == TGT_NONE) & ~none_err_q;
    end
  end

  ////////////////////////////////////////
  // Response return
  ////////////////////////////////////////

  always_comb begin
    case (tgt)
      TGT_L2: begin
        wb_dat_o = l2_bus.dat_r;
        wb_ack_o = l2_bus.ack;
        wb_err_o = l2_bus.err;
      end
      TGT_UART: begin
        wb_dat_o = uart_bus.dat_r;
        wb_ack_o = uart_bus.ack;
        wb_err_o = uart_bus.err;
      end
      TGT_CTRL: begin
        wb_dat_o = ctrl_bus.dat_r;
        wb_ack_o = ctrl_bus.ack;
        wb_err_o = ctrl_bus.err;
      end
      default: begin
        wb_dat_o = '0;
        wb_ack_o = 1'b0;
        wb_err_o = none_err_q;
      end
    endcase
  end

endmodule

// File: l2_mem.sv
// Word-wide memory with byte selects, one-cycle ack; contents undefined after reset
`timescale 1ns/1ps
`include "soc_config.svh"

module l2_mem import soc_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  wb_if.slave  bus
);

  localparam int unsigned idx_bits  = $clog2(`SOC_L2_WORDS);
  localparam int unsigned byte_bits = $clog2(`SOC_SEL_WIDTH);

  logic [`SOC_DATA_WIDTH-1:0] mem_q [`SOC_L2_WORDS];
  logic [`SOC_DATA_WIDTH-1:0] rdata_q;
  logic [idx_bits-1:0]        word_idx;
  logic                       access;
  logic                       ack_q;

  assign word_idx = bus.adr[idx_bits+byte_bits-1:byte_bits];

  // New request only while no ack is pending
  assign access = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (bus.we) begin
        mem_q[word_idx] <= apply_sel(mem_q[word_idx], bus.dat_w, bus.sel);
      end
      rdata_q <= mem_q[word_idx];
    end
  end

  assign bus.dat_r = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

endmodule

// File: uart_apb_bridge.sv
// One bus cycle becomes one APB transfer; whole words only, byte selects ignored
`timescale 1ns/1ps
`include "soc_config.svh"

module uart_apb_bridge import soc_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  wb_if.slave                            bus,
  output logic                           uart_psel_o,
  output logic                           uart_penable_o,
  output logic                           uart_pwrite_o,
  output logic [`SOC_APB_ADDR_WIDTH-1:0] uart_paddr_o,
  output logic [`SOC_DATA_WIDTH-1:0]     uart_pwdata_o,
  input  logic [`SOC_DATA_WIDTH-1:0]     uart_prdata_i,
  input  logic                           uart_pready_i,
  input  logic                           uart_pslverr_i
);

  apb_state_e                     state_q;
  apb_state_e                     state_d;
  logic [`SOC_APB_ADDR_WIDTH-1:0] paddr_q;
  logic                           pwrite_q;
  logic [`SOC_DATA_WIDTH-1:0]     pwdata_q;
  logic [`SOC_DATA_WIDTH-1:0]     prdata_q;
  logic                           pslverr_q;

  ////////////////////////////////////////
  // Transfer FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      APB_IDLE: begin
        if (bus.cyc && bus.stb) state_d = APB_SETUP;
      end
      APB_SETUP: state_d = APB_ACCESS;
      APB_ACCESS: begin
        // Wait states stretch ACCESS
        if (uart_pready_i) state_d = APB_DONE;
      end
      APB_DONE: state_d = APB_IDLE;
      default: state_d = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= APB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request captured on entry to SETUP, response on the pready edge
  always_ff @(posedge clk_i) begin
    if (state_q == APB_IDLE && bus.cyc && bus.stb) begin
      paddr_q  <= bus.adr[`SOC_APB_ADDR_WIDTH-1:0];
      pwrite_q <= bus.we;
      pwdata_q <= bus.dat_w;
    end
    if (state_q == APB_ACCESS && uart_pready_i) begin
      prdata_q  <= uart_prdata_i;
      pslverr_q <= uart_pslverr_i;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign uart_psel_o    = (state_q == APB_SETUP) || (state_q == APB_ACCESS);
  assign uart_penable_o = (state_q == APB_ACCESS);
  assign uart_pwrite_o  = pwrite_q;
  assign uart_paddr_o   = paddr_q;
  assign uart_pwdata_o  = pwdata_q;

  assign bus.dat_r = prdata_q;
  assign bus.ack   = (state_q == APB_DONE) & ~pslverr_q;
  assign bus.err   = (state_q == APB_DONE) & pslverr_q;

endmodule

// File: ctrl_regs.sv
// Exit and counter-enable registers plus read-only memory window bounds; other offsets err
`timescale 1ns/1ps
`include "soc_config.svh"

module ctrl_regs import soc_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  wb_if.slave                        bus,
  output logic [`SOC_DATA_WIDTH-1:0] exit_o,
  output logic [`SOC_DATA_WIDTH-1:0] hw_cnt_en_o
);

  ctrl_reg_e                  reg_sel;
  logic                       reg_hit;
  logic                       req_new;
  logic                       ack_q;
  logic                       err_q;
  logic [`SOC_DATA_WIDTH-1:0] exit_q;
  logic [`SOC_DATA_WIDTH-1:0] hw_cnt_en_q;
  logic [`SOC_DATA_WIDTH-1:0] rdata_q;

  assign reg_sel = ctrl_reg_e'(bus.adr[`SOC_APB_ADDR_WIDTH-1:0]);
  assign reg_hit = reg_sel inside {REG_EXIT, REG_HW_CNT_EN, REG_DRAM_BASE, REG_DRAM_END};
  assign req_new = bus.cyc & bus.stb & ~ack_q & ~err_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q       <= 1'b0;
      err_q       <= 1'b0;
      exit_q      <= '0;
      hw_cnt_en_q <= '0;
    end else begin
      ack_q <= req_new & reg_hit;
      err_q <= req_new & ~reg_hit;
      if (req_new && bus.we) begin
        // Window bound registers swallow writes
        case (reg_sel)
          REG_EXIT:      exit_q      <= apply_sel(exit_q, bus.dat_w, bus.sel);
          REG_HW_CNT_EN: hw_cnt_en_q <= apply_sel(hw_cnt_en_q, bus.dat_w, bus.sel);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_new) begin
      case (reg_sel)
        REG_EXIT:      rdata_q <= exit_q;
        REG_HW_CNT_EN: rdata_q <= hw_cnt_en_q;
        REG_DRAM_BASE: rdata_q <= `SOC_DRAM_BASE;
        REG_DRAM_END:  rdata_q <= `SOC_DRAM_BASE + `SOC_DRAM_LENGTH;
        default:       rdata_q <= '0;
      endcase
    end
  end

  assign bus.dat_r   = rdata_q;
  assign bus.ack     = ack_q;
  assign bus.err     = err_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = hw_cnt_en_q;

endmodule

// File: soc_top.sv
// Peripheral subsystem behind one Wishbone slave port; UART lives outside on APB
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Bus port from the external master
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [`SOC_ADDR_WIDTH-1:0]     wb_adr_i,
  input  logic [`SOC_DATA_WIDTH-1:0]     wb_dat_i,
  input  logic [`SOC_SEL_WIDTH-1:0]      wb_sel_i,
  output logic [`SOC_DATA_WIDTH-1:0]     wb_dat_o,
  output logic                           wb_ack_o,
  output logic                           wb_err_o,
  // Control outputs
  output logic [`SOC_DATA_WIDTH-1:0]     exit_o,
  output logic [`SOC_DATA_WIDTH-1:0]     hw_cnt_en_o,
  // UART APB master
  output logic                           uart_psel_o,
  output logic                           uart_penable_o,
  output logic                           uart_pwrite_o,
  output logic [`SOC_APB_ADDR_WIDTH-1:0] uart_paddr_o,
  output logic [`SOC_DATA_WIDTH-1:0]     uart_pwdata_o,
  input  logic [`SOC_DATA_WIDTH-1:0]     uart_prdata_i,
  input  logic                           uart_pready_i,
  input  logic                           uart_pslverr_i
);

  wb_if l2_bus ();
  wb_if uart_bus ();
  wb_if ctrl_bus ();

  soc_decoder u_decoder (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .l2_bus   (l2_bus.master),
    .uart_bus (uart_bus.master),
    .ctrl_bus (ctrl_bus.master)
  );

  l2_mem u_l2_mem (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (l2_bus.slave)
  );

  uart_apb_bridge u_uart_bridge (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .bus            (uart_bus.slave),
    .uart_psel_o    (uart_psel_o),
    .uart_penable_o (uart_penable_o),
    .uart_pwrite_o  (uart_pwrite_o),
    .uart_paddr_o   (uart_paddr_o),
    .uart_pwdata_o  (uart_pwdata_o),
    .uart_prdata_i  (uart_prdata_i),
    .uart_pready_i  (uart_pready_i),
    .uart_pslverr_i (uart_pslverr_i)
  );

  ctrl_regs u_ctrl_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus         (ctrl_bus.slave),
    .exit_o      (exit_o),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

endmodule

// File: soc_sva.sv
// Bus and APB protocol properties on soc_top ports; inactive while reset is low
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_sva (
  input logic                           clk_i,
  input logic                           rst_n_i,
  input logic                           wb_cyc_i,
  input logic                           wb_stb_i,
  input logic                           wb_ack_i,
  input logic                           wb_err_i,
  input logic                           psel_i,
  input logic                           penable_i,
  input logic [`SOC_APB_ADDR_WIDTH-1:0] paddr_i,
  input logic                           pready_i
);

  int unsigned fail_count = 0;

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wb_ack_i && wb_err_i))
    else begin
      $error("ack and err high together");
      fail_count++;
    end

  a_resp_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_ack_i || wb_err_i) |-> (wb_cyc_i && wb_stb_i))
    else begin
      $error("response without request");
      fail_count++;
    end

  a_single_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_ack_i)
    else begin
      $error("ack high two cycles in a row");
      fail_count++;
    end

  // Transfer holds until the peripheral is ready
  a_psel_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (psel_i && !pready_i) |=> (psel_i && $stable(paddr_i)))
    else begin
      $error("psel or paddr moved");
      fail_count++;
    end

  a_setup_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(penable_i) |-> $past(psel_i && !penable_i))
    else begin
      $error("penable without SETUP");
      fail_count++;
    end

endmodule

bind soc_top soc_sva u_sva (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .wb_cyc_i  (wb_cyc_i),
  .wb_stb_i  (wb_stb_i),
  .wb_ack_i  (wb_ack_o),
  .wb_err_i  (wb_err_o),
  .psel_i    (uart_psel_o),
  .penable_i (uart_penable_o),
  .paddr_i   (uart_paddr_o),
  .pready_i  (uart_pready_i)
);

// File: soc_tb.sv
// Needs soc_config.svh on the include path; the run stops at the first mismatch
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_tb import soc_pkg::*; ();

  localparam int n_mem       = 32;
  localparam int n_ctrl      = 4;
  localparam int n_uart      = 32;
  localparam int n_err       = 8;
  localparam int n_ops       = 2 * n_mem + 4 * n_ctrl + 4 + n_uart + 3 * n_err;
  localparam int cycle_limit = 40 * n_ops;

  logic                           clk_i = 1'b0;
  logic                           rst_n_i;
  logic                           wb_cyc_i, wb_stb_i, wb_we_i;
  logic [`SOC_ADDR_WIDTH-1:0]     wb_adr_i;
  logic [`SOC_DATA_WIDTH-1:0]     wb_dat_i, wb_dat_o;
  logic [`SOC_SEL_WIDTH-1:0]      wb_sel_i;
  logic                           wb_ack_o, wb_err_o;
  logic [`SOC_DATA_WIDTH-1:0]     exit_o, hw_cnt_en_o;
  logic                           uart_psel_o, uart_penable_o, uart_pwrite_o;
  logic [`SOC_APB_ADDR_WIDTH-1:0] uart_paddr_o;
  logic [`SOC_DATA_WIDTH-1:0]     uart_pwdata_o;
  logic [`SOC_DATA_WIDTH-1:0]     uart_prdata_i = '0;
  logic                           uart_pready_i = 1'b0;
  logic                           uart_pslverr_i = 1'b0;

  // APB peripheral model state
  logic [`SOC_DATA_WIDTH-1:0]     uart_regs [8];
  int                             wait_left;
  int                             apb_count = 0;
  int                             apb_last_waits;
  logic [`SOC_APB_ADDR_WIDTH-1:0] apb_last_addr;
  logic                           apb_last_write;
  int                             cycle_cnt = 0;
  int                             err_count = 0;

  soc_top dut (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] byte_merge(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic bit in_any_window(input logic [31:0] adr);
    return (adr >= `SOC_DRAM_BASE && adr < `SOC_DRAM_BASE + `SOC_DRAM_LENGTH) ||
           (adr >= `SOC_UART_BASE && adr < `SOC_UART_BASE + `SOC_UART_LENGTH) ||
           (adr >= `SOC_CTRL_BASE && adr < `SOC_CTRL_BASE + `SOC_CTRL_LENGTH);
  endfunction

  function automatic logic [31:0] uart_fill(input int idx);
    return 32'hA5A5_0000 ^ (idx * 32'h0001_0203);
  endfunction

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // One Wishbone classic cycle with stb held through the edge that samples ack or err
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                           input logic [3:0] sel, output logic [31:0] rdata,
                           output logic ack, output logic err, output int lat);
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    wb_sel_i = sel;
    lat = 0;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!(wb_ack_o || wb_err_o));
    rdata = wb_dat_o;
    ack   = wb_ack_o;
    err   = wb_err_o;
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  ////////////////////////////////////////
  // APB peripheral with 8 words and 0 to 3 wait states
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    uart_pready_i  = 1'b0;
    uart_pslverr_i = 1'b0;
    uart_prdata_i  = '0;
    if (!rst_n_i) begin
      for (int i = 0; i < 8; i++) uart_regs[i] = uart_fill(i);
    end else if (uart_psel_o && !uart_penable_o) begin
      wait_left      = $urandom_range(3, 0);
      apb_last_waits = wait_left;
      apb_last_addr  = uart_paddr_o;
      apb_last_write = uart_pwrite_o;
      apb_count++;
    end else if (uart_psel_o && uart_penable_o) begin
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        uart_pready_i = 1'b1;
        if (uart_paddr_o >= 12'h020) uart_pslverr_i = 1'b1;
        else if (uart_pwrite_o) uart_regs[uart_paddr_o[4:2]] = uart_pwdata_o;
        else uart_prdata_i = uart_regs[uart_paddr_o[4:2]];
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the bus tests did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation timed out");
    end
  end

  // Bound protocol checker failures end the run at once
  always @(negedge clk_i) begin
    if (dut.u_sva.fail_count != 0) begin
      $display("A bus or APB protocol assertion failed");
      $display("ERRORS FOUND");
      $fatal(1, "Protocol assertion failed");
    end
  end

  ////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////

  initial begin
    logic [31:0]  rd, wd, adr, exit_exp, hw_exp;
    logic [31:0]  mem_model [int unsigned];
    logic [31:0]  uart_exp [8];
    int unsigned  written [$];
    int unsigned  idx;
    logic [11:0]  off;
    logic [3:0]   sel;
    logic         ack, err, we;
    int           lat, apb_before;

    void'($urandom(86202));
    rst_n_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    exit_exp = '0;
    hw_exp   = '0;
    for (int i = 0; i < 8; i++) uart_exp[i] = uart_fill(i);
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;

    check_equal("wb_ack_o after reset", wb_ack_o, 1'b0);
    check_equal("wb_err_o after reset", wb_err_o, 1'b0);
    check_equal("uart_psel_o after reset", uart_psel_o, 1'b0);
    check_equal("uart_penable_o after reset", uart_penable_o, 1'b0);
    check_equal("exit_o after reset", exit_o, '0);
    check_equal("hw_cnt_en_o after reset", hw_cnt_en_o, '0);

    // First memory write to a word covers all bytes
    repeat (n_mem) begin
      idx = $urandom_range(`SOC_L2_WORDS - 1, 0);
      wd  = $urandom;
      sel = mem_model.exists(idx) ? 4'($urandom) : 4'hF;
      bus_cycle(1'b1, `SOC_DRAM_BASE + idx * 4, wd, sel, rd, ack, err, lat);
      check_equal("mem write ack", ack, 1'b1);
      check_equal("mem write latency", lat, 1);
      if (!mem_model.exists(idx)) begin
        written.push_back(idx);
        mem_model[idx] = wd;
      end else begin
        mem_model[idx] = byte_merge(mem_model[idx], wd, sel);
      end
      idx = written[$urandom_range(written.size() - 1, 0)];
      bus_cycle(1'b0, `SOC_DRAM_BASE + idx * 4, '0, 4'hF, rd, ack, err, lat);
      check_equal("mem read ack", ack, 1'b1);
      check_equal("mem read latency", lat, 1);
      check_equal("mem read data", rd, mem_model[idx]);
    end

    // Control registers
    repeat (n_ctrl) begin
      for (int r = 0; r < 2; r++) begin
        off = (r == 0) ? REG_EXIT : REG_HW_CNT_EN;
        wd  = $urandom;
        sel = 4'($urandom);
        bus_cycle(1'b1, `SOC_CTRL_BASE + off, wd, sel, rd, ack, err, lat);
        if (r == 0) exit_exp = byte_merge(exit_exp, wd, sel);
        else hw_exp = byte_merge(hw_exp, wd, sel);
        check_equal("ctrl write ack", ack, 1'b1);
        check_equal("ctrl write latency", lat, 1);
        check_equal("exit_o", exit_o, exit_exp);
        check_equal("hw_cnt_en_o", hw_cnt_en_o, hw_exp);
        bus_cycle(1'b0, `SOC_CTRL_BASE + off, '0, 4'hF, rd, ack, err, lat);
        check_equal("ctrl read ack", ack, 1'b1);
        check_equal("ctrl readback", rd, (r == 0) ? exit_exp : hw_exp);
      end
    end
    bus_cycle(1'b1, `SOC_CTRL_BASE + REG_DRAM_BASE, $urandom, 4'hF, rd, ack, err, lat);
    check_equal("dram base write ack", ack, 1'b1);
    bus_cycle(1'b1, `SOC_CTRL_BASE + REG_DRAM_END, $urandom, 4'hF, rd, ack, err, lat);
    check_equal("dram end write ack", ack, 1'b1);
    bus_cycle(1'b0, `SOC_CTRL_BASE + REG_DRAM_BASE, '0, 4'hF, rd, ack, err, lat);
    check_equal("dram base read", rd, 32'h8000_0000);
    bus_cycle(1'b0, `SOC_CTRL_BASE + REG_DRAM_END, '0, 4'hF, rd, ack, err, lat);
    check_equal("dram end read", rd, 32'h8000_1000);
    repeat (n_err) begin
      off = 12'h010 + 4 * $urandom_range(1019, 0);
      bus_cycle(1'($urandom), `SOC_CTRL_BASE + off, $urandom, 4'hF, rd, ack, err, lat);
      check_equal("ctrl unlisted err", err, 1'b1);
      check_equal("ctrl unlisted ack", ack, 1'b0);
      check_equal("ctrl unlisted latency", lat, 1);
      check_equal("exit_o after err", exit_o, exit_exp);
      check_equal("hw_cnt_en_o after err", hw_cnt_en_o, hw_exp);
    end

    // UART over APB
    repeat (n_uart) begin
      idx = $urandom_range(7, 0);
      off = idx * 4;
      wd  = $urandom;
      we  = 1'($urandom);
      apb_before = apb_count;
      bus_cycle(we, `SOC_UART_BASE + off, wd, 4'($urandom), rd, ack, err, lat);
      check_equal("uart ack", ack, 1'b1);
      check_equal("uart err", err, 1'b0);
      check_equal("apb transfer count", apb_count, apb_before + 1);
      check_equal("apb paddr", apb_last_addr, off);
      check_equal("apb pwrite", apb_last_write, we);
      check_equal("uart latency", lat, 3 + apb_last_waits);
      if (we) begin
        uart_exp[idx] = wd;
        check_equal("uart register after write", uart_regs[idx], wd);
      end else begin
        check_equal("uart read data", rd, uart_exp[idx]);
      end
    end
    repeat (n_err) begin
      off = 12'h020 + 4 * $urandom_range(1015, 0);
      apb_before = apb_count;
      bus_cycle(1'($urandom), `SOC_UART_BASE + off, $urandom, 4'hF, rd, ack, err, lat);
      check_equal("uart high offset err", err, 1'b1);
      check_equal("uart high offset ack", ack, 1'b0);
      check_equal("apb transfer count", apb_count, apb_before + 1);
      check_equal("uart err latency", lat, 3 + apb_last_waits);
    end

    // Unmapped addresses
    repeat (n_err) begin
      do adr = $urandom; while (in_any_window(adr));
      apb_before = apb_count;
      bus_cycle(1'($urandom), adr, $urandom, 4'hF, rd, ack, err, lat);
      check_equal("unmapped err", err, 1'b1);
      check_equal("unmapped ack", ack, 1'b0);
      check_equal("unmapped latency", lat, 1);
      check_equal("apb transfer count", apb_count, apb_before);
      check_equal("exit_o after unmapped", exit_o, exit_exp);
      check_equal("hw_cnt_en_o after unmapped", hw_cnt_en_o, hw_exp);
    end

    repeat (2) @(negedge clk_i);
    if (err_count == 0 && dut.u_sva.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+.
soc_pkg.sv
wb_if.sv
soc_decoder.sv
l2_mem.sv
uart_apb_bridge.sv
ctrl_regs.sv
soc_top.sv
soc_sva.sv
soc_tb.sv

// File: Bender.yml
package:
  name: soc_periph

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - soc_pkg.sv
      - wb_if.sv
      - soc_decoder.sv
      - l2_mem.sv
      - uart_apb_bridge.sv
      - ctrl_regs.sv
      - soc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - soc_sva.sv
      - soc_tb.sv
